/* build.f */
rtl/isa_pkg.sv
rtl/exec_pkg.sv
rtl/ex_mem_if.sv
rtl/alu_control.sv
rtl/alu.sv
rtl/operand_forward.sv
rtl/exec_ctrl.sv
rtl/exec_result_reg.sv
rtl/exec_top.sv
verif/exec_assert.sv
verif/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - rtl/isa_pkg.sv
  - rtl/exec_pkg.sv
  - rtl/ex_mem_if.sv
  - rtl/alu_control.sv
  - rtl/alu.sv
  - rtl/operand_forward.sv
  - rtl/exec_ctrl.sv
  - rtl/exec_result_reg.sv
  - rtl/exec_top.sv
  - target: simulation
    files:
      - verif/exec_assert.sv
      - verif/exec_tb.sv

/* verif/exec_tb.sv */
module exec_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int period     = 40;
   localparam int n_txn      = 200;                    // Accepted inputs per random test
   localparam int n_tests    = 6;
   localparam int timeout_ns = (n_tests - 1) * n_txn * 4 * period + 100 * period;
   localparam int m_alu      = 0;
   localparam int m_branch   = 1;
   localparam int m_fwd      = 2;
   localparam int m_bp       = 3;
   localparam int m_pass     = 4;

   typedef struct packed {
      logic rw, rd, wr, m2r, br, z, ov;
      logic [isa_pkg::reg_size-1:0]  res;
      logic [isa_pkg::reg_size-1:0]  st;
      logic [isa_pkg::addr_size-1:0] pcb;
      logic [isa_pkg::reg_addr-1:0]  dst;
   } bundle_t;

   logic                          clk, reset, in_valid, in_ready, out_ready, out_valid;
   logic [5:0]                    opcode, funct_code;
   logic [isa_pkg::reg_size-1:0]  src1, reg2, immediat, alu_result, data_store;
   logic [isa_pkg::addr_size-1:0] old_pc, pc_branch;
   logic [isa_pkg::reg_addr-1:0]  src1_addr, src2_addr, dst_reg_in, dst_reg;
   logic                          alusrc, regwrite_in, do_read, do_write, memtoreg, is_branch_in;
   logic                          regwrite_out, zero, overflow, do_read_out, do_write_out;
   logic                          memtoreg_out, is_branch_out;

   // Reference copy of the last accepted instruction
   bit                            m_valid;
   logic                          m_rw, m_m2r;
   logic [isa_pkg::reg_addr-1:0]  m_dst;
   logic [isa_pkg::reg_size-1:0]  m_res;

   bundle_t exp_q[$];
   int      checks, errors, test_errs, seed_ret;
   string   cur_test;

   logic [5:0] op_list [13] = '{6'h00, 6'h04, 6'h05, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
                                6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b};
   logic [5:0] fn_list [13] = '{6'h04, 6'h06, 6'h07, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

   exec_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Returns {overflow, result} by the MIPS rules
   function automatic logic [32:0] ref_alu(input logic [5:0] op, input logic [5:0] fn,
                                           input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r;
      logic        v;
      logic [5:0]  k;
      logic [32:0] w;
      r = '0;
      v = 1'b0;
      case (op)
         6'h00:               k = fn;
         6'h08, 6'h23, 6'h2b: k = 6'h20;
         6'h09:               k = 6'h21;
         6'h04, 6'h05:        k = 6'h22;
         6'h0a:               k = 6'h2a;
         6'h0b:               k = 6'h2b;
         6'h0c:               k = 6'h24;
         6'h0d:               k = 6'h25;
         6'h0e:               k = 6'h26;
         6'h0f:               k = 6'h01;             // lui, no funct equivalent
         default:             k = 6'h3f;
      endcase
      case (k)
         6'h20: begin
            w = {a[31], a} + {b[31], b};               // 33-bit signed sum
            r = w[31:0];
            v = w[32] != w[31];                        // Out of 32-bit signed range
         end
         6'h21: r = a + b;
         6'h22: begin
            w = {a[31], a} - {b[31], b};
            r = w[31:0];
            v = w[32] != w[31];
         end
         6'h23: r = a - b;
         6'h24: r = a & b;
         6'h25: r = a | b;
         6'h26: r = a ^ b;
         6'h27: r = ~(a | b);
         6'h2a: r = {31'b0, $signed(a) < $signed(b)};
         6'h2b: r = {31'b0, a < b};
         6'h04: r = b << a[4:0];
         6'h06: r = b >> a[4:0];
         6'h07: r = $signed(b) >>> a[4:0];
         6'h01: r = {b[15:0], 16'h0};
         default: r = '0;                              // Unlisted codes give zero
      endcase
      return {v, r};
   endfunction

   function automatic logic [31:0] rand_word();
      case ($urandom_range(7))
         0:       return 32'h7fff_ffff;
         1:       return 32'h8000_0000;
         2:       return 32'h0;
         3:       return 32'hffff_ffff;
         default: return $urandom;
      endcase
   endfunction

   task automatic check(input string field, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         test_errs++;
         $display("error: %s %s expected 0x%h actual 0x%h", cur_test, field, expected, actual);
      end
   endtask

   task automatic gen_instr(input int mode);
      logic [15:0] imm16;
      opcode     = op_list[$urandom_range(12)];
      funct_code = fn_list[$urandom_range(12)];
      if ($urandom_range(15) == 0) opcode = 6'h3f;     // Occasional nop decode
      if ($urandom_range(15) == 0) funct_code = 6'h3f;
      src1         = rand_word();
      reg2         = rand_word();
      imm16        = 16'($urandom);
      immediat     = {{16{imm16[15]}}, imm16};         // Sign-extended like decode does
      old_pc       = {$urandom} & ~32'h3;
      src1_addr    = $urandom_range(31);
      src2_addr    = $urandom_range(31);
      dst_reg_in   = $urandom_range(31);
      regwrite_in  = $urandom_range(1);
      do_read      = $urandom_range(1);
      do_write     = $urandom_range(1);
      memtoreg     = $urandom_range(1);
      is_branch_in = 1'b0;
      case (mode)
         m_alu: regwrite_in = 1'b0;                    // Keeps the history out of play
         m_branch: begin
            opcode       = $urandom_range(1) ? 6'h04 : 6'h05;
            is_branch_in = 1'b1;
            regwrite_in  = 1'b0;
            if ($urandom_range(1)) reg2 = src1;
         end
         m_fwd, m_bp: begin
            src1_addr   = $urandom_range(3);           // Small range, frequent hazards
            src2_addr   = $urandom_range(3);
            dst_reg_in  = $urandom_range(3);
            regwrite_in = $urandom_range(3) != 0;
            memtoreg    = $urandom_range(3) == 0;
         end
         default: ;
      endcase
      alusrc = (opcode == 6'h00) || (opcode == 6'h04) || (opcode == 6'h05);
   endtask

   task automatic model_accept();
      logic                         f;
      logic [isa_pkg::reg_size-1:0] a, b2;
      logic [32:0]                  r;
      bundle_t                      e;
      f  = m_valid && m_rw && !m_m2r && (m_dst != 0);
      a  = (f && m_dst == src1_addr) ? m_res : src1;
      b2 = (f && m_dst == src2_addr) ? m_res : reg2;
      r  = ref_alu(opcode, funct_code, a, alusrc ? b2 : immediat);
      e.rw  = regwrite_in;
      e.rd  = do_read;
      e.wr  = do_write;
      e.m2r = memtoreg;
      e.br  = is_branch_in;
      e.z   = (r[31:0] == 0);
      e.ov  = r[32];
      e.res = r[31:0];
      e.st  = b2;
      e.pcb = old_pc + immediat * 4;
      e.dst = dst_reg_in;
      exp_q.push_back(e);
      m_valid = 1'b1;
      m_rw    = regwrite_in;
      m_m2r   = memtoreg;
      m_dst   = dst_reg_in;
      m_res   = r[31:0];
   endtask

   task automatic compare_out();
      bundle_t e;
      if (exp_q.size() == 0) begin
         errors++;
         test_errs++;
         $display("%s: DUT delivered an output with no accepted input left to match", cur_test);
      end else begin
         e = exp_q.pop_front();
         check("alu_result", e.res, alu_result);
         check("zero", e.z, zero);
         check("overflow", e.ov, overflow);
         check("pc_branch", e.pcb, pc_branch);
         check("data_store", e.st, data_store);
         check("dst_reg", e.dst, dst_reg);
         check("regwrite", e.rw, regwrite_out);
         check("do_read", e.rd, do_read_out);
         check("do_write", e.wr, do_write_out);
         check("memtoreg", e.m2r, memtoreg_out);
         check("is_branch", e.br, is_branch_out);
      end
   endtask

   task automatic run_test(input string name, input int mode);
      int acc;
      bit pending;
      bit lat_due;
      cur_test  = name;
      test_errs = 0;
      acc       = 0;
      pending   = 0;
      lat_due   = 0;
      while (acc < n_txn || exp_q.size() != 0) begin
         @(negedge clk);
         if (!pending) begin                           // Held inputs stay put until taken
            in_valid = (acc < n_txn) && ($urandom_range(3) != 0);
            if (in_valid) gen_instr(mode);
         end
         out_ready = (mode == m_bp) ? ($urandom_range(9) > 3) : 1'b1;
         #1;
         if (lat_due) check("latency out_valid", 1, out_valid);
         if (out_valid && out_ready) compare_out();
         lat_due = in_valid && in_ready;
         pending = in_valid && !in_ready;
         if (in_valid && in_ready) begin
            model_accept();
            acc++;
         end
      end
      $display("test %s finished with %0d errors", cur_test, test_errs);
   endtask

   initial begin
      seed_ret = $urandom(32'h107f_7fcb);
      {reset, in_valid, out_ready} = 3'b100;
      {opcode, funct_code, src1, reg2, immediat, old_pc} = '0;
      {src1_addr, src2_addr, dst_reg_in} = '0;
      {alusrc, regwrite_in, do_read, do_write, memtoreg, is_branch_in} = '0;
      {checks, errors, m_valid} = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset     = 1'b0;
      cur_test  = "reset_state";
      test_errs = 0;
      #1;
      check("in_ready", 1, in_ready);
      check("out_valid", 0, out_valid);
      check("control bits", 0, {regwrite_out, do_read_out, do_write_out, memtoreg_out,
                                is_branch_out, zero, overflow});
      $display("test %s finished with %0d errors", cur_test, test_errs);
      run_test("alu_ops", m_alu);
      run_test("branch_target", m_branch);
      run_test("forwarding", m_fwd);
      run_test("back_pressure", m_bp);
      run_test("pass_through", m_pass);
      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("timeout: the DUT did not finish the transactions in the allowed time");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* verif/exec_assert.sv */
module exec_assert (
   input logic                          clk,
   input logic                          reset,
   input logic                          in_ready,
   input logic                          out_valid,
   input logic                          out_ready,
   input logic                          regwrite_out,
   input logic                          zero,
   input logic                          overflow,
   input logic                          do_read_out,
   input logic                          do_write_out,
   input logic                          memtoreg_out,
   input logic                          is_branch_out,
   input logic [isa_pkg::reg_size-1:0]  alu_result,
   input logic [isa_pkg::reg_size-1:0]  data_store,
   input logic [isa_pkg::addr_size-1:0] pc_branch,
   input logic [isa_pkg::reg_addr-1:0]  dst_reg
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int bundle_w = 7 + 2 * isa_pkg::reg_size + isa_pkg::addr_size + isa_pkg::reg_addr;

   logic [bundle_w-1:0] bundle;                        // Everything downstream sees

   assign bundle = {regwrite_out, zero, overflow, do_read_out, do_write_out, memtoreg_out,
                    is_branch_out, alu_result, data_store, pc_branch, dst_reg};

   reset_clears: assert property (@(posedge clk)
      reset |=> !out_valid && !regwrite_out && !do_read_out && !do_write_out &&
                !memtoreg_out && !is_branch_out)
      else $error("stage register not cleared by reset");

   // Stalled output must hold
   hold_stable: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(bundle))
      else $error("output bundle changed while stalled");

   ready_rule: assert property (@(posedge clk) disable iff (reset)
      in_ready == (!out_valid || out_ready))
      else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind exec_top exec_assert u_assert (.*);

/* rtl/exec_top.sv */
module exec_top (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [5:0]                    opcode,
   input  logic [5:0]                    funct_code,
   input  logic [isa_pkg::reg_size-1:0]  src1,
   input  logic [isa_pkg::reg_size-1:0]  reg2,
   input  logic [isa_pkg::reg_addr-1:0]  src1_addr,
   input  logic [isa_pkg::reg_addr-1:0]  src2_addr,
   input  logic [isa_pkg::reg_size-1:0]  immediat,     // Already sign-extended
   input  logic [isa_pkg::addr_size-1:0] old_pc,       // PC plus 4
   input  logic [isa_pkg::reg_addr-1:0]  dst_reg_in,
   input  logic                          alusrc,
   input  logic                          regwrite_in,
   input  logic                          do_read,
   input  logic                          do_write,
   input  logic                          memtoreg,
   input  logic                          is_branch_in,
   input  logic                          out_ready,
   output logic                          out_valid,
   output logic                          regwrite_out,
   output logic                          zero,
   output logic                          overflow,
   output logic [isa_pkg::reg_size-1:0]  alu_result,
   output logic [isa_pkg::reg_size-1:0]  data_store,
   output logic [isa_pkg::addr_size-1:0] pc_branch,
   output logic                          do_read_out,
   output logic                          do_write_out,
   output logic                          memtoreg_out,
   output logic                          is_branch_out,
   output logic [isa_pkg::reg_addr-1:0]  dst_reg
);

   exec_pkg::aluop_e             aluop;
   logic [isa_pkg::reg_size-1:0] op_a;
   logic [isa_pkg::reg_size-1:0] op_b;
   logic [isa_pkg::reg_size-1:0] store_data;
   logic [isa_pkg::reg_size-1:0] result;
   logic                         alu_zero;
   logic                         alu_overflow;
   logic                         stage_en;
   logic                         fwd_valid;

   ex_mem_if ex_mem ();

   exec_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .out_ready (out_ready),
      .in_ready  (in_ready),
      .stage_en  (stage_en),
      .fwd_valid (fwd_valid),
      .ex_mem    (ex_mem.consumer)
   );

   // Raw fields may hold unlisted codes, which decode to nop
   alu_control u_alu_control (
      .opcode     (isa_pkg::opcode_e'(opcode)),
      .funct_code (isa_pkg::funct_e'(funct_code)),
      .aluop      (aluop)
   );

   operand_forward u_fwd (
      .src1       (src1),
      .reg2       (reg2),
      .immediat   (immediat),
      .src1_addr  (src1_addr),
      .src2_addr  (src2_addr),
      .alusrc     (alusrc),
      .fwd_valid  (fwd_valid),
      .ex_mem     (ex_mem.consumer),
      .op_a       (op_a),
      .op_b       (op_b),
      .store_data (store_data)
   );

   alu u_alu (
      .aluop    (aluop),
      .src1     (op_a),
      .src2     (op_b),
      .result   (result),
      .zero     (alu_zero),
      .overflow (alu_overflow)
   );

   exec_result_reg u_result_reg (
      .clk          (clk),
      .reset        (reset),
      .stage_en     (stage_en),
      .out_ready    (out_ready),
      .result       (result),
      .store_data   (store_data),
      .immediat     (immediat),
      .zero         (alu_zero),
      .overflow     (alu_overflow),
      .old_pc       (old_pc),
      .dst_reg_in   (dst_reg_in),
      .regwrite_in  (regwrite_in),
      .do_read      (do_read),
      .do_write     (do_write),
      .memtoreg     (memtoreg),
      .is_branch_in (is_branch_in),
      .ex_mem       (ex_mem.producer)
   );

   // Bundle out to plain ports
   assign out_valid     = ex_mem.valid;
   assign regwrite_out  = ex_mem.regwrite;
   assign zero          = ex_mem.zero;
   assign overflow      = ex_mem.overflow;
   assign alu_result    = ex_mem.alu_result;
   assign data_store    = ex_mem.data_store;
   assign pc_branch     = ex_mem.pc_branch;
   assign do_read_out   = ex_mem.do_read;
   assign do_write_out  = ex_mem.do_write;
   assign memtoreg_out  = ex_mem.memtoreg;
   assign is_branch_out = ex_mem.is_branch;
   assign dst_reg       = ex_mem.dst_reg;

endmodule

/* rtl/exec_result_reg.sv */
module exec_result_reg (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          stage_en,
   input  logic                          out_ready,
   input  logic [isa_pkg::reg_size-1:0]  result,
   input  logic [isa_pkg::reg_size-1:0]  store_data,
   input  logic [isa_pkg::reg_size-1:0]  immediat,
   input  logic                          zero,
   input  logic                          overflow,
   input  logic [isa_pkg::addr_size-1:0] old_pc,
   input  logic [isa_pkg::reg_addr-1:0]  dst_reg_in,
   input  logic                          regwrite_in,
   input  logic                          do_read,
   input  logic                          do_write,
   input  logic                          memtoreg,
   input  logic                          is_branch_in,
   ex_mem_if.producer                    ex_mem
);

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem.valid     <= 1'b0;
         ex_mem.regwrite  <= 1'b0;
         ex_mem.do_read   <= 1'b0;
         ex_mem.do_write  <= 1'b0;
         ex_mem.memtoreg  <= 1'b0;
         ex_mem.is_branch <= 1'b0;
         ex_mem.zero      <= 1'b0;
         ex_mem.overflow  <= 1'b0;
      end else if (stage_en) begin
         ex_mem.valid     <= 1'b1;
         ex_mem.regwrite  <= regwrite_in;
         ex_mem.do_read   <= do_read;
         ex_mem.do_write  <= do_write;
         ex_mem.memtoreg  <= memtoreg;
         ex_mem.is_branch <= is_branch_in;
         ex_mem.zero      <= zero;
         ex_mem.overflow  <= overflow;
      end else if (out_ready) begin
         ex_mem.valid <= 1'b0;                   // Controls stay for forwarding
      end
   end

   always_ff @(posedge clk) begin
      if (stage_en) begin
         ex_mem.alu_result <= result;
         ex_mem.data_store <= store_data;
         ex_mem.pc_branch  <= old_pc + (immediat << exec_pkg::branch_shift);
         ex_mem.dst_reg    <= dst_reg_in;
      end
   end

endmodule

/* rtl/exec_ctrl.sv */
module exec_ctrl (
   input  logic       clk,
   input  logic       reset,
   input  logic       in_valid,
   input  logic       out_ready,
   output logic       in_ready,
   output logic       stage_en,
   output logic       fwd_valid,
   ex_mem_if.consumer ex_mem
);

   // Room when the register is empty or drains this cycle
   assign in_ready = !ex_mem.valid || out_ready;
   assign stage_en = in_valid && in_ready;

   // History becomes meaningful once the first entry lands
   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_valid <= 1'b0;
      end else if (stage_en) begin
         fwd_valid <= 1'b1;
      end
   end

endmodule

/* rtl/operand_forward.sv */
module operand_forward (
   input  logic [isa_pkg::reg_size-1:0] src1,
   input  logic [isa_pkg::reg_size-1:0] reg2,
   input  logic [isa_pkg::reg_size-1:0] immediat,
   input  logic [isa_pkg::reg_addr-1:0] src1_addr,
   input  logic [isa_pkg::reg_addr-1:0] src2_addr,
   input  logic                         alusrc,     // High selects register, low immediate
   input  logic                         fwd_valid,
   ex_mem_if.consumer                   ex_mem,
   output logic [isa_pkg::reg_size-1:0] op_a,
   output logic [isa_pkg::reg_size-1:0] op_b,
   output logic [isa_pkg::reg_size-1:0] store_data
);

   logic                         prev_writes;
   logic                         fwd1;
   logic                         fwd2;
   logic [isa_pkg::reg_size-1:0] reg2_fwd;

   // Loads are not forwarded since their data comes from memory
   assign prev_writes = fwd_valid && ex_mem.regwrite && !ex_mem.memtoreg &&
                        (ex_mem.dst_reg != '0);

   assign fwd1 = prev_writes && (ex_mem.dst_reg == src1_addr);
   assign fwd2 = prev_writes && (ex_mem.dst_reg == src2_addr);

   assign op_a     = fwd1 ? ex_mem.alu_result : src1;
   assign reg2_fwd = fwd2 ? ex_mem.alu_result : reg2;

   assign store_data = reg2_fwd;                             // Stores see the fresh value too
   assign op_b       = alusrc ? reg2_fwd : immediat;

endmodule

/* rtl/alu.sv */
module alu (
   input  exec_pkg::aluop_e             aluop,
   input  logic [isa_pkg::reg_size-1:0] src1,
   input  logic [isa_pkg::reg_size-1:0] src2,
   output logic [isa_pkg::reg_size-1:0] result,
   output logic                         zero,
   output logic                         overflow
);

   localparam int msb = isa_pkg::reg_size - 1;

   logic [isa_pkg::reg_size-1:0] sum;
   logic [isa_pkg::reg_size-1:0] diff;
   logic [exec_pkg::shamt_w-1:0] shamt;
   logic                         add_ovf;
   logic                         sub_ovf;

   assign sum   = src1 + src2;
   assign diff  = src1 - src2;
   assign shamt = src1[exec_pkg::shamt_w-1:0];              // Variable shifts take rs

   // Same signs in, different sign out
   assign add_ovf = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
   // Different signs in, result sign follows src2
   assign sub_ovf = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);

   always_comb begin
      result   = '0;
      overflow = 1'b0;
      case (aluop)
         exec_pkg::alu_add: begin
            result   = sum;
            overflow = add_ovf;
         end
         exec_pkg::alu_addu: result = sum;
         exec_pkg::alu_sub: begin
            result   = diff;
            overflow = sub_ovf;
         end
         exec_pkg::alu_subu: result = diff;
         exec_pkg::alu_and:  result = src1 & src2;
         exec_pkg::alu_or:   result = src1 | src2;
         exec_pkg::alu_xor:  result = src1 ^ src2;
         exec_pkg::alu_nor:  result = ~(src1 | src2);
         exec_pkg::alu_slt:  result = {{msb{1'b0}}, $signed(src1) < $signed(src2)};
         exec_pkg::alu_sltu: result = {{msb{1'b0}}, src1 < src2};
         exec_pkg::alu_sll:  result = src2 << shamt;
         exec_pkg::alu_srl:  result = src2 >> shamt;
         exec_pkg::alu_sra:  result = $signed(src2) >>> shamt;  // Sign fill
         exec_pkg::alu_lui:  result = src2 << exec_pkg::lui_shift;
         default:            result = '0;                       // nop
      endcase
   end

   assign zero = (result == '0);

endmodule

/* rtl/alu_control.sv */
module alu_control (
   input  isa_pkg::opcode_e opcode,
   input  isa_pkg::funct_e  funct_code,
   output exec_pkg::aluop_e aluop
);

   exec_pkg::aluop_e rtype_op;

   // R-type operation by funct
   always_comb begin
      case (funct_code)
         isa_pkg::fn_sllv: rtype_op = exec_pkg::alu_sll;
         isa_pkg::fn_srlv: rtype_op = exec_pkg::alu_srl;
         isa_pkg::fn_srav: rtype_op = exec_pkg::alu_sra;
         isa_pkg::fn_add:  rtype_op = exec_pkg::alu_add;
         isa_pkg::fn_addu: rtype_op = exec_pkg::alu_addu;
         isa_pkg::fn_sub:  rtype_op = exec_pkg::alu_sub;
         isa_pkg::fn_subu: rtype_op = exec_pkg::alu_subu;
         isa_pkg::fn_and:  rtype_op = exec_pkg::alu_and;
         isa_pkg::fn_or:   rtype_op = exec_pkg::alu_or;
         isa_pkg::fn_xor:  rtype_op = exec_pkg::alu_xor;
         isa_pkg::fn_nor:  rtype_op = exec_pkg::alu_nor;
         isa_pkg::fn_slt:  rtype_op = exec_pkg::alu_slt;
         isa_pkg::fn_sltu: rtype_op = exec_pkg::alu_sltu;
         default:          rtype_op = exec_pkg::alu_nop;   // Unknown funct
      endcase
   end

   always_comb begin
      case (opcode)
         isa_pkg::op_rtype: aluop = rtype_op;
         isa_pkg::op_addi,
         isa_pkg::op_lw,
         isa_pkg::op_sw:    aluop = exec_pkg::alu_add;     // Address calc uses add
         isa_pkg::op_addiu: aluop = exec_pkg::alu_addu;
         isa_pkg::op_beq,
         isa_pkg::op_bne:   aluop = exec_pkg::alu_sub;     // Compare drives zero
         isa_pkg::op_slti:  aluop = exec_pkg::alu_slt;
         isa_pkg::op_sltiu: aluop = exec_pkg::alu_sltu;
         isa_pkg::op_andi:  aluop = exec_pkg::alu_and;
         isa_pkg::op_ori:   aluop = exec_pkg::alu_or;
         isa_pkg::op_xori:  aluop = exec_pkg::alu_xor;
         isa_pkg::op_lui:   aluop = exec_pkg::alu_lui;
         default:           aluop = exec_pkg::alu_nop;
      endcase
   end

endmodule

/* rtl/ex_mem_if.sv */
interface ex_mem_if;

   logic                        valid;           // Stage register holds an unconsumed entry
   logic                        regwrite;
   logic                        do_read;
   logic                        do_write;
   logic                        memtoreg;        // Result comes from data memory
   logic                        is_branch;
   logic                        zero;
   logic                        overflow;
   logic [isa_pkg::reg_size-1:0]  alu_result;
   logic [isa_pkg::reg_size-1:0]  data_store;
   logic [isa_pkg::addr_size-1:0] pc_branch;
   logic [isa_pkg::reg_addr-1:0]  dst_reg;

   // Written only by the stage register
   modport producer (
      output valid, regwrite, do_read, do_write, memtoreg, is_branch,
      output zero, overflow, alu_result, data_store, pc_branch, dst_reg
   );

   // Control and forwarding logic look back at the stored entry
   modport consumer (
      input valid, regwrite, do_read, do_write, memtoreg, is_branch,
      input zero, overflow, alu_result, data_store, pc_branch, dst_reg
   );

endinterface

/* rtl/exec_pkg.sv */
package exec_pkg;

   localparam int branch_shift = 2;              // Word offset to byte offset
   localparam int shamt_w      = 5;              // Shift amount bits taken from src1
   localparam int lui_shift    = 16;             // Upper half placement for lui

   // Internal ALU operations, decoupled from the ISA encoding
   typedef enum logic [4:0] {
      alu_nop  = 5'd0,                           // Result forced to zero
      alu_add  = 5'd1,                           // Signed, flags overflow
      alu_addu = 5'd2,
      alu_sub  = 5'd3,                           // Signed, flags overflow
      alu_subu = 5'd4,
      alu_and  = 5'd5,
      alu_or   = 5'd6,
      alu_xor  = 5'd7,
      alu_nor  = 5'd8,
      alu_slt  = 5'd9,
      alu_sltu = 5'd10,
      alu_sll  = 5'd11,
      alu_srl  = 5'd12,
      alu_sra  = 5'd13,
      alu_lui  = 5'd14
   } aluop_e;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

   localparam int reg_size  = 32;                // Data path width
   localparam int addr_size = 32;                // PC width
   localparam int reg_addr  = 5;                 // Register file index width

   // Primary opcode field, bits 31:26
   typedef enum logic [5:0] {
      op_rtype = 6'h00,                          // Uses funct
      op_beq   = 6'h04,
      op_bne   = 6'h05,
      op_addi  = 6'h08,
      op_addiu = 6'h09,
      op_slti  = 6'h0a,
      op_sltiu = 6'h0b,
      op_andi  = 6'h0c,
      op_ori   = 6'h0d,
      op_xori  = 6'h0e,
      op_lui   = 6'h0f,
      op_lw    = 6'h23,
      op_sw    = 6'h2b
   } opcode_e;

   // Function field of R-type instructions, bits 5:0
   typedef enum logic [5:0] {
      fn_sllv = 6'h04,
      fn_srlv = 6'h06,
      fn_srav = 6'h07,
      fn_add  = 6'h20,
      fn_addu = 6'h21,
      fn_sub  = 6'h22,
      fn_subu = 6'h23,
      fn_and  = 6'h24,
      fn_or   = 6'h25,
      fn_xor  = 6'h26,
      fn_nor  = 6'h27,
      fn_slt  = 6'h2a,
      fn_sltu = 6'h2b
   } funct_e;

endpackage
